/* control_unit.f */
+incdir+test
hdl/isa_pkg.sv
hdl/ctrl_pkg.sv
hdl/instr_decoder.sv
hdl/step_sequencer.sv
hdl/control_word_gen.sv
hdl/control_unit.sv
test/control_unit_tb.sv

/* test/control_unit_tests.svh */
`ifndef CONTROL_UNIT_TESTS_SVH
`define CONTROL_UNIT_TESTS_SVH

// Class 0 is illegal, so the first instruction ends after decode
task automatic reset_and_fetch();
	int errors_before;
	errors_before = error_count;
	repeat (10) @(negedge clk);
	reset = 1'b1;
	#5;
	check_value("reset fetch0", mar_from_pc(), ctrl);
	for (int k = 1; k < 4; k++)
	begin
		@(negedge clk);
		#5;
		check_value($sformatf("reset cycle %0d", k), expected_word(8'h00, '0, k), ctrl);
	end
	finish_test("reset_and_fetch", errors_before);
endtask

task automatic immediate_loads();
	int          errors_before;
	logic [31:0] r;
	errors_before = error_count;
	random_bits(8, r);
	run_instr("lda", {CLS_LDA_IMM, r[3:0]}, ccr_t'(r[7:4]));
	random_bits(8, r);
	run_instr("ldb", {CLS_LDB_IMM, r[3:0]}, ccr_t'(r[7:4]));
	finish_test("immediate_loads", errors_before);
endtask

task automatic direct_stores();
	int          errors_before;
	logic [31:0] r;
	errors_before = error_count;
	random_bits(8, r);
	run_instr("sta", {CLS_STA_DIR, r[3:0]}, ccr_t'(r[7:4]));
	random_bits(8, r);
	run_instr("stb", {CLS_STB_DIR, r[3:0]}, ccr_t'(r[7:4]));
	finish_test("direct_stores", errors_before);
endtask

task automatic alu_operations();
	alu_sel_e    codes [4] = '{ALU_ADD, ALU_AND, ALU_OR, ALU_XOR};
	int          errors_before;
	logic [31:0] r;
	errors_before = error_count;
	for (int i = 0; i < 40; i++)
	begin
		random_bits(6, r);
		run_instr("alu", {CLS_ALU, 1'b0, codes[r[1:0]]}, ccr_t'(r[5:2]));
	end
	finish_test("alu_operations", errors_before);
endtask

// Eight conditional branches, then BRA
task automatic branches();
	int          errors_before;
	logic [31:0] r;
	errors_before = error_count;
	for (int fs = 0; fs < 4; fs++)
		for (int pol = 0; pol < 2; pol++)
			for (int i = 0; i < 4; i++)
			begin
				random_bits(4, r);
				run_instr("bcc", {CLS_BRANCH, 1'b0, 2'(fs), 1'(pol)}, ccr_t'(r[3:0]));
			end
	repeat (2)
	begin
		random_bits(7, r);
		run_instr("bra", {CLS_BRANCH, 1'b1, r[2:0]}, ccr_t'(r[6:3]));
	end
	finish_test("branches", errors_before);
endtask

task automatic illegal_opcodes();
	logic [2:0]  unused_codes [4] = '{3'b001, 3'b010, 3'b011, 3'b111};
	int          errors_before;
	logic [31:0] r;
	logic [7:0]  op;
	errors_before = error_count;
	for (int i = 0; i < 30; i++)
	begin
		random_bits(2, r);
		if (r[1:0] == 2'd0)
		begin
			random_bits(3, r);
			op = {CLS_ALU, 1'b1, r[2:0]};   // Reserved bit set
		end
		else if (r[1:0] == 2'd1)
		begin
			random_bits(2, r);
			op = {CLS_ALU, 1'b0, unused_codes[r[1:0]]};
		end
		else
		begin
			do
				random_bits(8, r);
			while (r[7:4] >= 4'd1 && r[7:4] <= 4'd6);   // Unknown class only
			op = r[7:0];
		end
		random_bits(4, r);
		run_instr("illegal", op, ccr_t'(r[3:0]));
	end
	@(negedge clk);
	#5;
	check_value("illegal back to fetch0", mar_from_pc(), ctrl);
	finish_test("illegal_opcodes", errors_before);
endtask

`endif

/* test/control_unit_tb.sv */
`timescale 1ns/1ps

module control_unit_tb;

	import isa_pkg::*;
	import ctrl_pkg::*;

	localparam logic [31:0] LFSR_SEED = 32'hec13_8887;
	localparam int TIMEOUT_CYCLES = 2 * 150 * 8 + 100;   // Twice 150 instructions of 8 cycles

	logic       clk;
	logic       reset;
	instr_u     instr;
	ccr_t       ccr;
	ctrl_word_t ctrl;

	logic [31:0] lfsr_state;
	int          cycle_count;
	int          error_count;
	int          test_count;

	control_unit u_dut (
		.clk   (clk),
		.reset (reset),
		.instr (instr),
		.ccr   (ccr),
		.ctrl  (ctrl)
	);

	always #10 clk = ~clk;   // 20 ns period

	// Fibonacci LFSR, taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic random_bits(input int n, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);   // One step per bit
			value      = {value[30:0], lfsr_state[0]};
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("ERROR %s: expected %h, actual %h", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic finish_test(input string name, input int errors_before);
		test_count++;
		$display("%s done, %0d errors", name, error_count - errors_before);
	endtask

	function automatic logic is_legal(input logic [7:0] op);
		case (op[7:4])
			4'd1, 4'd2, 4'd3, 4'd4, 4'd6: return 1'b1;
			4'd5:    return !op[3] && (op[2:0] inside {3'b000, 3'b100, 3'b101, 3'b110});
			default: return 1'b0;
		endcase
	endfunction

	// Branch view: always bit, or selected flag equal to polarity
	function automatic logic branch_taken(input logic [7:0] op, input ccr_t flags);
		logic flag;
		case (op[2:1])
			2'd3:    flag = flags.n;
			2'd2:    flag = flags.z;
			2'd1:    flag = flags.v;
			default: flag = flags.c;
		endcase
		return op[3] || (flag == op[0]);
	endfunction

	function automatic int instr_len(input logic [7:0] op, input ccr_t flags);
		if (!is_legal(op))
			return 4;
		case (op[7:4])
			4'd1, 4'd2: return 7;
			4'd3, 4'd4: return 8;
			4'd5:       return 5;
			default:    return branch_taken(op, flags) ? 7 : 5;
		endcase
	endfunction

	function automatic ctrl_word_t mar_from_pc();
		ctrl_word_t w;
		w          = '0;
		w.mar_load = 1'b1;
		w.bus1_sel = BUS1_PC;
		w.bus2_sel = BUS2_BUS1;
		return w;
	endfunction

	// Expected control word for cycle k of an instruction
	function automatic ctrl_word_t expected_word(input logic [7:0] op, input ccr_t flags,
		input int k);
		ctrl_word_t w;
		int         e;
		w = '0;
		e = k - 4;
		case (k)
			0: w = mar_from_pc();
			1:
			begin
				w.ir_load  = 1'b1;
				w.bus2_sel = BUS2_MEM;
			end
			2: w.pc_inc = 1'b1;
			3: ;   // Decode
			default:
			begin
				if (is_legal(op))
				begin
					case (op[7:4])
						4'd1, 4'd2, 4'd3, 4'd4:
						begin
							if (e == 0)
								w = mar_from_pc();
							else if (e == 1)
								w.pc_inc = 1'b1;
							else if (e == 2 && op[7:4] <= 4'd2)
							begin
								w.a_load   = (op[7:4] == 4'd1);
								w.b_load   = (op[7:4] == 4'd2);
								w.bus2_sel = BUS2_MEM;
							end
							else if (e == 2)
							begin
								w.mar_load = 1'b1;   // Store address byte
								w.bus2_sel = BUS2_MEM;
							end
							else if (e == 3)
							begin
								w.write    = 1'b1;
								w.bus1_sel = (op[7:4] == 4'd3) ? BUS1_A : BUS1_B;
								w.bus2_sel = BUS2_BUS1;
							end
						end
						4'd5:
						begin
							w.a_load   = 1'b1;
							w.ccr_load = 1'b1;
							w.alu_sel  = alu_sel_e'(op[2:0]);
							w.bus1_sel = BUS1_B;
						end
						default:
						begin
							if (!branch_taken(op, flags))
								w.pc_inc = 1'b1;
							else if (e == 0)
								w = mar_from_pc();
							else
							begin
								w.pc_load  = (e == 2);
								w.bus2_sel = BUS2_MEM;
							end
						end
					endcase
				end
			end
		endcase
		return w;
	endfunction

	// Drives one instruction and checks every cycle of it
	task automatic run_instr(input string name, input logic [7:0] op, input ccr_t flags);
		int len;
		len = instr_len(op, flags);
		for (int k = 0; k < len; k++)
		begin
			@(negedge clk);
			if (k == 0)
			begin
				instr = op;
				ccr   = flags;
			end
			#5;   // Mid low phase
			check_value($sformatf("%s %h cycle %0d", name, op, k),
				expected_word(op, flags, k), ctrl);
		end
	endtask

	`include "control_unit_tests.svh"

	initial
	begin
		clk         = 1'b0;
		reset       = 1'b0;
		instr       = '0;
		ccr         = '0;
		lfsr_state  = LFSR_SEED;
		error_count = 0;
		test_count  = 0;
		reset_and_fetch();
		immediate_loads();
		direct_stores();
		alu_operations();
		branches();
		illegal_opcodes();
		$display("Tests: %0d, errors: %0d", test_count, error_count);
		if (error_count == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	initial
	begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES)
		begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

endmodule

/* hdl/control_unit.sv */
`timescale 1ns/1ps

module control_unit (
	input  logic                  clk,
	input  logic                  reset,
	input  isa_pkg::instr_u       instr,   // IR contents from the datapath
	input  isa_pkg::ccr_t         ccr,
	output ctrl_pkg::ctrl_word_t  ctrl
);

	import ctrl_pkg::*;

	decoded_t dec;
	step_t    step;

	instr_decoder u_decoder (
		.instr (instr),
		.ccr   (ccr),
		.dec   (dec)
	);

	step_sequencer u_sequencer (
		.clk      (clk),
		.reset    (reset),
		.exec_len (dec.exec_len),
		.step     (step)
	);

	// Output word is combinational from step and decode
	control_word_gen u_word_gen (
		.step (step),
		.dec  (dec),
		.ctrl (ctrl)
	);

endmodule

/* hdl/control_word_gen.sv */
`timescale 1ns/1ps

module control_word_gen (
	input  ctrl_pkg::step_t     step,
	input  ctrl_pkg::decoded_t  dec,
	output ctrl_pkg::ctrl_word_t ctrl
);

	import isa_pkg::*;
	import ctrl_pkg::*;

	step_t exec_step;   // Index within the execute phase

	assign exec_step = step - STEP_EXEC0;

	// Put PC on bus1 and route it into MAR
	function automatic ctrl_word_t pc_to_mar();
		ctrl_word_t w;
		w          = '0;
		w.mar_load = 1'b1;
		w.bus1_sel = BUS1_PC;
		w.bus2_sel = BUS2_BUS1;
		return w;
	endfunction

	always_comb
	begin
		ctrl = '0;
		case (step)
			STEP_FETCH0: ctrl = pc_to_mar();
			STEP_FETCH1:
			begin
				ctrl.ir_load  = 1'b1;   // Opcode from memory
				ctrl.bus2_sel = BUS2_MEM;
			end
			STEP_FETCH2: ctrl.pc_inc = 1'b1;
			STEP_DECODE: ;   // Decoder settles, nothing driven
			default:
			begin
				if (dec.legal)
				begin
					case (dec.cls)
						CLS_LDA_IMM, CLS_LDB_IMM:
						begin
							case (exec_step)
								3'd0: ctrl = pc_to_mar();
								3'd1: ctrl.pc_inc = 1'b1;
								3'd2:
								begin
									if (dec.cls == CLS_LDA_IMM)
										ctrl.a_load = 1'b1;
									else
										ctrl.b_load = 1'b1;
									ctrl.bus2_sel = BUS2_MEM;   // Operand byte
								end
								default: ;
							endcase
						end
						CLS_STA_DIR, CLS_STB_DIR:
						begin
							case (exec_step)
								3'd0: ctrl = pc_to_mar();
								3'd1: ctrl.pc_inc = 1'b1;
								3'd2:
								begin
									ctrl.mar_load = 1'b1;   // Target address from memory
									ctrl.bus2_sel = BUS2_MEM;
								end
								3'd3:
								begin
									ctrl.write = 1'b1;
									if (dec.cls == CLS_STA_DIR)
										ctrl.bus1_sel = BUS1_A;
									else
										ctrl.bus1_sel = BUS1_B;
									ctrl.bus2_sel = BUS2_BUS1;
								end
								default: ;
							endcase
						end
						CLS_ALU:
						begin
							if (exec_step == 3'd0)
							begin
								ctrl.a_load   = 1'b1;
								ctrl.ccr_load = 1'b1;
								ctrl.alu_sel  = dec.alu_sel;
								ctrl.bus1_sel = BUS1_B;   // Second operand
								ctrl.bus2_sel = BUS2_ALU;
							end
						end
						CLS_BRANCH:
						begin
							if (dec.taken)
							begin
								case (exec_step)
									3'd0: ctrl = pc_to_mar();
									3'd1: ctrl.bus2_sel = BUS2_MEM;   // Memory access wait
									3'd2:
									begin
										ctrl.pc_load  = 1'b1;   // Jump target
										ctrl.bus2_sel = BUS2_MEM;
									end
									default: ;
								endcase
							end
							else if (exec_step == 3'd0)
								ctrl.pc_inc = 1'b1;   // Step over target byte
						end
						default: ;
					endcase
				end
			end
		endcase
	end

	// Memory is written only from A or B, never while a register loads
	a_write_excl: assert final (!(ctrl.write && (ctrl.ir_load || ctrl.mar_load ||
		ctrl.pc_load || ctrl.a_load || ctrl.b_load || ctrl.ccr_load)));

endmodule

/* hdl/step_sequencer.sv */
`timescale 1ns/1ps

module step_sequencer (
	input  logic                 clk,
	input  logic                 reset,
	input  ctrl_pkg::exec_len_t  exec_len,
	output ctrl_pkg::step_t      step
);

	import ctrl_pkg::*;

	step_t last_step;   // Final step of the current instruction

	// Fetch steps never reach last_step, so exec_len only matters from decode on
	assign last_step = STEP_DECODE + exec_len;

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
			step <= STEP_FETCH0;
		else if (step >= last_step)
			step <= STEP_FETCH0;   // End of instruction
		else
			step <= step + step_t'(1);
	end

	// Counter never runs past the last step of the current instruction
	a_step_range: assert property (
		@(posedge clk) disable iff (!reset)
		step <= last_step
	);

	// Any backwards move of the counter is a return to fetch
	a_wrap_to_fetch: assert property (
		@(posedge clk) disable iff (!reset)
		(step < $past(step)) |-> (step == STEP_FETCH0)
	);

endmodule

/* hdl/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder (
	input  isa_pkg::instr_u     instr,
	input  isa_pkg::ccr_t       ccr,
	output ctrl_pkg::decoded_t  dec
);

	import isa_pkg::*;
	import ctrl_pkg::*;

	logic sel_flag;      // Flag picked by the branch view
	logic alu_code_ok;

	// Flag multiplexer for conditional branches
	always_comb
	begin
		case (instr.br.flag_sel)
			FLAG_N:  sel_flag = ccr.n;
			FLAG_Z:  sel_flag = ccr.z;
			FLAG_V:  sel_flag = ccr.v;
			default: sel_flag = ccr.c;
		endcase
	end

	// Only four of the eight ALU codes exist
	always_comb
	begin
		case (instr.alu.alu_sel)
			ALU_ADD, ALU_AND, ALU_OR, ALU_XOR: alu_code_ok = 1'b1;
			default:                           alu_code_ok = 1'b0;
		endcase
	end

	always_comb
	begin
		dec.cls      = instr.alu.cls;
		dec.legal    = 1'b0;
		dec.alu_sel  = ALU_ADD;
		dec.taken    = 1'b0;
		dec.exec_len = EXEC_LEN_NONE;
		case (instr.alu.cls)
			CLS_LDA_IMM, CLS_LDB_IMM:
			begin
				dec.legal    = 1'b1;
				dec.exec_len = EXEC_LEN_IMM;
			end
			CLS_STA_DIR, CLS_STB_DIR:
			begin
				dec.legal    = 1'b1;
				dec.exec_len = EXEC_LEN_STORE;
			end
			CLS_ALU:
			begin
				if (!instr.alu.rsvd && alu_code_ok)
				begin
					dec.legal    = 1'b1;
					dec.alu_sel  = instr.alu.alu_sel;
					dec.exec_len = EXEC_LEN_ALU;
				end
			end
			CLS_BRANCH:
			begin
				dec.legal = 1'b1;
				dec.taken = instr.br.uncond || (sel_flag == instr.br.polarity);
				if (dec.taken)
					dec.exec_len = EXEC_LEN_BR_TAKEN;
				else
					dec.exec_len = EXEC_LEN_BR_SKIP;   // Skip the target byte
			end
			default: ;   // Unknown class, back to fetch after decode
		endcase
	end

	a_exec_len_max: assert final (dec.exec_len <= MAX_EXEC_LEN);

endmodule

/* hdl/ctrl_pkg.sv */
package ctrl_pkg;

	typedef logic [2:0] step_t;       // Step within one instruction
	typedef logic [2:0] exec_len_t;   // Execute steps, 0 to 4

	// Fixed steps shared by every instruction
	localparam step_t STEP_FETCH0 = 3'd0;   // PC to MAR
	localparam step_t STEP_FETCH1 = 3'd1;   // Opcode into IR
	localparam step_t STEP_FETCH2 = 3'd2;   // PC + 1
	localparam step_t STEP_DECODE = 3'd3;
	localparam step_t STEP_EXEC0  = 3'd4;   // First execute step

	localparam int MAX_EXEC_LEN = 4;

	// Execute length per instruction kind
	localparam exec_len_t EXEC_LEN_IMM      = 3'd3;
	localparam exec_len_t EXEC_LEN_STORE    = 3'd4;
	localparam exec_len_t EXEC_LEN_ALU      = 3'd1;
	localparam exec_len_t EXEC_LEN_BR_TAKEN = 3'd3;
	localparam exec_len_t EXEC_LEN_BR_SKIP  = 3'd1;
	localparam exec_len_t EXEC_LEN_NONE     = 3'd0;   // Illegal opcode

	typedef enum logic [1:0] {
		BUS1_PC = 2'd0,
		BUS1_A  = 2'd1,
		BUS1_B  = 2'd2
	} bus1_sel_e;

	typedef enum logic [1:0] {
		BUS2_ALU  = 2'd0,
		BUS2_BUS1 = 2'd1,
		BUS2_MEM  = 2'd2
	} bus2_sel_e;

	// Strobes to the datapath for one cycle
	typedef struct packed {
		logic               ir_load;
		logic               mar_load;
		logic               pc_load;
		logic               pc_inc;
		logic               a_load;
		logic               b_load;
		logic               ccr_load;
		logic               write;      // Memory write strobe
		isa_pkg::alu_sel_e  alu_sel;
		bus1_sel_e          bus1_sel;
		bus2_sel_e          bus2_sel;
	} ctrl_word_t;

	typedef struct packed {
		isa_pkg::instr_class_e cls;
		logic                  legal;
		isa_pkg::alu_sel_e     alu_sel;
		logic                  taken;     // Branch condition met
		exec_len_t             exec_len;
	} decoded_t;

endpackage

/* hdl/isa_pkg.sv */
package isa_pkg;

	// Opcode class in the top nibble of the instruction byte
	typedef enum logic [3:0] {
		CLS_LDA_IMM = 4'd1,   // A <= next byte
		CLS_LDB_IMM = 4'd2,   // B <= next byte
		CLS_STA_DIR = 4'd3,   // mem[next byte] <= A
		CLS_STB_DIR = 4'd4,   // mem[next byte] <= B
		CLS_ALU     = 4'd5,   // A <= A op B, flags updated
		CLS_BRANCH  = 4'd6    // PC <= next byte when condition holds
	} instr_class_e;

	// ALU function codes as the datapath ALU decodes them
	typedef enum logic [2:0] {
		ALU_ADD = 3'b000,
		ALU_AND = 3'b100,
		ALU_OR  = 3'b101,
		ALU_XOR = 3'b110
	} alu_sel_e;

	// Flag index used by conditional branches
	typedef enum logic [1:0] {
		FLAG_C = 2'd0,
		FLAG_V = 2'd1,
		FLAG_Z = 2'd2,
		FLAG_N = 2'd3
	} flag_sel_e;

	// Condition code register, MSB first
	typedef struct packed {
		logic n;   // Negative
		logic z;   // Zero
		logic v;   // Overflow
		logic c;   // Carry
	} ccr_t;

	// Low nibble of an ALU instruction
	typedef struct packed {
		instr_class_e cls;
		logic         rsvd;      // Must be 0
		alu_sel_e     alu_sel;
	} alu_view_t;

	// Low nibble of a branch instruction
	typedef struct packed {
		instr_class_e cls;
		logic         uncond;    // Branch regardless of flags
		flag_sel_e    flag_sel;
		logic         polarity;  // 1 branches on flag set
	} branch_view_t;

	// One instruction byte, read either way
	typedef union packed {
		alu_view_t    alu;
		branch_view_t br;
	} instr_u;

endpackage
